// File: rtl/core_defs.svh
// ************************************************
// Core width definitions
// Data width, register index width and the
// iteration count of the multiply/divide unit
// ************************************************

`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data and address width
`define XLEN 32

// Register index width, x0..x31
`define REG_ADDR_W 5

// One shift-add or restoring step per operand bit
`define DIV_STEPS `XLEN

`endif

// File: rtl/rv_isa_pkg.sv
// ************************************************
// RV32 ISA enumerations
// Operation codes of the M and A extension subsets
// handled in the execute stage
// ************************************************

package rv_isa_pkg;

  // M extension, unsigned subset only
  // Low and high product select the two halves of one 64-bit result
  typedef enum logic [1:0] {
    MD_MUL   = 2'd0,
    MD_MULHU = 2'd1,
    MD_DIVU  = 2'd2,
    MD_REMU  = 2'd3
  } md_op_e;

  // A extension read-modify-write operations
  // LR/SC are not part of this set
  typedef enum logic [2:0] {
    AMO_SWAP = 3'd0,
    AMO_ADD  = 3'd1,
    AMO_AND  = 3'd2,
    AMO_OR   = 3'd3,
    AMO_XOR  = 3'd4
  } amo_op_e;

endpackage

// File: rtl/pipe_pkg.sv
// ************************************************
// Pipeline bundle types
// ID/EX instruction bundle, data memory request
// and execute-stage result
// ************************************************

`include "core_defs.svh"

package pipe_pkg;

  // Register index
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // One instruction held in ID/EX
  // An all-zero bundle is a NOP bubble
  typedef struct packed {
    logic                valid;
    reg_addr_t           rd;
    reg_addr_t           rs1;
    reg_addr_t           rs2;
    // Class flags, at most one set
    logic                mem_read;
    logic                is_mul_div;
    logic                is_atomic;
    // Sub-operation within the class
    rv_isa_pkg::md_op_e  md_op;
    rv_isa_pkg::amo_op_e amo_op;
    // Operand values read in ID
    logic [`XLEN-1:0]    rs1_val;
    logic [`XLEN-1:0]    rs2_val;
  } idex_t;

  // Data memory request from the atomic sequencer
  // Strobes are single-cycle
  typedef struct packed {
    logic             read;
    logic             write;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
  } mem_req_t;

  // Result of a multi-cycle unit, valid for one cycle
  typedef struct packed {
    logic             valid;
    reg_addr_t        rd;
    logic [`XLEN-1:0] data;
  } ex_result_t;

endpackage

// File: rtl/hazard_detection_unit.sv
// ************************************************
// Hazard detection unit
// Load-use bubble plus hold of ID/EX while a
// multi-cycle unit occupies EX
// ************************************************

`timescale 1ns/1ps

module hazard_detection_unit (
  // Instruction in ID/EX
  input  logic                idex_mem_read,
  input  pipe_pkg::reg_addr_t idex_rd,
  // Sources of the instruction in ID
  input  pipe_pkg::reg_addr_t ifid_rs1,
  input  pipe_pkg::reg_addr_t ifid_rs2,
  // M unit
  input  logic                md_busy,
  input  logic                idex_is_mul_div,
  // A unit
  input  logic                amo_busy,
  input  logic                amo_done,
  input  logic                md_done,
  input  logic                idex_is_atomic,
  // Front-end and ID/EX control
  output logic                stall_pc,
  output logic                stall_ifid,
  output logic                bubble_idex,
  output logic                idex_hold
);

  logic load_use;
  logic m_stall;
  logic a_stall;

  // Load in EX writes a register ID is about to read
  // x0 never carries a dependency
  assign load_use = idex_mem_read && (idex_rd != '0) &&
                    ((idex_rd == ifid_rs1) || (idex_rd == ifid_rs2));

  // Flag catches the first cycle, before busy rises
  // Done lets the instruction leave ID/EX
  assign m_stall = (md_busy || idex_is_mul_div) && !md_done;
  assign a_stall = (amo_busy || idex_is_atomic) && !amo_done;

  // Front end waits on any of the three
  assign stall_pc   = load_use || m_stall || a_stall;
  assign stall_ifid = load_use || m_stall || a_stall;

  // Load-use inserts a NOP, multi-cycle ops keep the instruction in place
  assign bubble_idex = load_use;
  assign idex_hold   = m_stall || a_stall;

endmodule

// File: rtl/mul_div_unit.sv
// ************************************************
// Iterative multiply/divide unit
// Shift-add multiply and restoring divide for
// MUL, MULHU, DIVU and REMU, one bit per cycle
// ************************************************

`timescale 1ns/1ps

`include "core_defs.svh"

module mul_div_unit (
  input  logic                 clk,
  input  logic                 reset,
  input  pipe_pkg::idex_t      idex,
  output logic                 busy,
  output logic                 done,
  output pipe_pkg::ex_result_t result
);

  import rv_isa_pkg::*;
  import pipe_pkg::*;

  localparam int CNT_W = $clog2(`DIV_STEPS + 1);

  // Multiply: {high partial, multiplier}, divide: {remainder, quotient}
  logic [2*`XLEN-1:0] acc_q;
  logic [2*`XLEN-1:0] acc_init;
  logic [2*`XLEN-1:0] acc_next;
  // Multiplicand or divisor
  logic [`XLEN-1:0]   opnd_q;
  md_op_e             op_q;
  reg_addr_t          rd_q;
  logic [CNT_W-1:0]   count_q;
  logic               start;

  function automatic logic op_is_div(input md_op_e op);
    return (op == MD_DIVU) || (op == MD_REMU);
  endfunction

  // One iteration of either algorithm
  function automatic logic [2*`XLEN-1:0] md_step(
    input logic [2*`XLEN-1:0] acc_in,
    input logic [`XLEN-1:0]   opnd,
    input logic               div_mode
  );
    logic [`XLEN:0]     sum;
    logic [`XLEN:0]     rem_sh;
    logic [`XLEN:0]     diff;
    logic [2*`XLEN-1:0] acc_out;
    if (div_mode) begin
      // Remainder shifted left with the next dividend bit
      rem_sh = acc_in[2*`XLEN-1:`XLEN-1];
      diff   = rem_sh - {1'b0, opnd};
      if (rem_sh >= {1'b0, opnd}) begin
        acc_out = {diff[`XLEN-1:0], acc_in[`XLEN-2:0], 1'b1};
      end else begin
        acc_out = {rem_sh[`XLEN-1:0], acc_in[`XLEN-2:0], 1'b0};
      end
    end else begin
      // Add multiplicand on a set LSB, then shift right with carry
      sum     = {1'b0, acc_in[2*`XLEN-1:`XLEN]} + {1'b0, {`XLEN{acc_in[0]}} & opnd};
      acc_out = {sum, acc_in[`XLEN-1:1]};
    end
    return acc_out;
  endfunction

  // Idle and not in the done cycle, otherwise the same op would restart
  assign start = idex.valid && idex.is_mul_div && !busy && !done;

  assign acc_init = {{`XLEN{1'b0}}, idex.rs1_val};

  // First step is taken in the start cycle
  always_comb begin
    if (busy) begin
      acc_next = md_step(acc_q, opnd_q, op_is_div(op_q));
    end else begin
      acc_next = md_step(acc_init, idex.rs2_val, op_is_div(idex.md_op));
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (start || busy) begin
      acc_q <= acc_next;
    end
    if (start) begin
      opnd_q <= idex.rs2_val;
      op_q   <= idex.md_op;
      rd_q   <= idex.rd;
    end
  end

  // Step counter, done pulses after the last step
  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      count_q <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy    <= 1'b1;
        count_q <= CNT_W'(1);
      end else if (busy) begin
        count_q <= count_q + 1'b1;
        if (count_q == CNT_W'(`DIV_STEPS - 1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // Divide by zero needs no special case
  // quotient ends all ones, remainder ends as the dividend
  always_comb begin
    result.valid = done;
    result.rd    = rd_q;
    case (op_q)
      MD_MULHU, MD_REMU: result.data = acc_q[2*`XLEN-1:`XLEN];
      default:           result.data = acc_q[`XLEN-1:0];
    endcase
  end

endmodule

// File: rtl/atomic_unit.sv
// ************************************************
// Atomic memory operation sequencer
// Read, modify and write back one memory word,
// returning the old value
// ************************************************

`timescale 1ns/1ps

`include "core_defs.svh"

module atomic_unit (
  input  logic                 clk,
  input  logic                 reset,
  input  pipe_pkg::idex_t      idex,
  input  logic [`XLEN-1:0]     mem_rdata,
  output logic                 busy,
  output logic                 done,
  output pipe_pkg::mem_req_t   mem_req,
  output pipe_pkg::ex_result_t result
);

  import rv_isa_pkg::*;
  import pipe_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    READ,
    MODIFY,
    WRITE
  } amo_state_e;

  amo_state_e       state_q;
  amo_state_e       state_cur;
  amo_state_e       state_next;
  logic             start;
  // Word read from memory and the value to write back
  logic [`XLEN-1:0] old_q;
  logic [`XLEN-1:0] new_q;

  function automatic logic [`XLEN-1:0] amo_calc(
    input amo_op_e          op,
    input logic [`XLEN-1:0] mem_val,
    input logic [`XLEN-1:0] src
  );
    logic [`XLEN-1:0] res;
    case (op)
      AMO_ADD: res = mem_val + src;
      AMO_AND: res = mem_val & src;
      AMO_OR:  res = mem_val | src;
      AMO_XOR: res = mem_val ^ src;
      default: res = src;
    endcase
    return res;
  endfunction

  assign start = idex.valid && idex.is_atomic && (state_q == IDLE);

  // READ is entered straight from IDLE in the start cycle
  assign state_cur = start ? READ : state_q;

  always_comb begin
    case (state_cur)
      READ:    state_next = MODIFY;
      MODIFY:  state_next = WRITE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_next;
    end
  end

  // Memory answers in the cycle after the read strobe
  always_ff @(posedge clk) begin
    if (state_cur == MODIFY) begin
      old_q <= mem_rdata;
      new_q <= amo_calc(idex.amo_op, mem_rdata, idex.rs2_val);
    end
  end

  assign busy = (state_q != IDLE);
  assign done = (state_cur == WRITE);

  // Address comes from rs1, held in ID/EX for the whole sequence
  assign mem_req.read  = (state_cur == READ);
  assign mem_req.write = (state_cur == WRITE);
  assign mem_req.addr  = idex.rs1_val;
  assign mem_req.wdata = new_q;

  // rd returns the old memory word
  assign result.valid = done;
  assign result.rd    = idex.rd;
  assign result.data  = old_q;

endmodule

// File: rtl/pipe_reg.sv
// ************************************************
// Pipeline register
// Hold, bubble or load of any packed payload
// ************************************************

`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     hold,
  input  logic     bubble,
  input  payload_t d,
  output payload_t q
);

  // Hold wins over bubble
  always_ff @(posedge clk) begin
    if (reset) begin
      q <= payload_t'('0);
    end else if (hold) begin
      q <= q;
    end else if (bubble) begin
      // All-zero payload is a NOP
      q <= payload_t'('0);
    end else begin
      q <= d;
    end
  end

endmodule

// File: rtl/ex_stall_top.sv
// ************************************************
// Execute-stage stall control
// ID/EX register, M and A units, hazard detection
// and the EX result register
// ************************************************

`timescale 1ns/1ps

`include "core_defs.svh"

module ex_stall_top (
  input  logic                 clk,
  input  logic                 reset,
  input  pipe_pkg::idex_t      id_instr,
  input  logic [`XLEN-1:0]     mem_rdata,
  output logic                 stall_pc,
  output logic                 stall_ifid,
  output pipe_pkg::mem_req_t   mem_req,
  output pipe_pkg::ex_result_t result_out
);

  import pipe_pkg::*;

  idex_t      idex_q;
  logic       bubble_idex;
  logic       idex_hold;
  logic       md_busy;
  logic       md_done;
  ex_result_t md_result;
  logic       amo_busy;
  logic       amo_done;
  ex_result_t amo_result;
  // Result register input, zero when no unit finishes
  ex_result_t ex_result_d;
  logic       no_result;

  // ID/EX register
  pipe_reg #(
    .payload_t (idex_t)
  ) idex_reg_i (
    .clk    (clk),
    .reset  (reset),
    .hold   (idex_hold),
    .bubble (bubble_idex),
    .d      (id_instr),
    .q      (idex_q)
  );

  mul_div_unit mul_div_unit_i (
    .clk    (clk),
    .reset  (reset),
    .idex   (idex_q),
    .busy   (md_busy),
    .done   (md_done),
    .result (md_result)
  );

  atomic_unit atomic_unit_i (
    .clk       (clk),
    .reset     (reset),
    .idex      (idex_q),
    .mem_rdata (mem_rdata),
    .busy      (amo_busy),
    .done      (amo_done),
    .mem_req   (mem_req),
    .result    (amo_result)
  );

  hazard_detection_unit hazard_detection_unit_i (
    .idex_mem_read   (idex_q.mem_read),
    .idex_rd         (idex_q.rd),
    .ifid_rs1        (id_instr.rs1),
    .ifid_rs2        (id_instr.rs2),
    .md_busy         (md_busy),
    .idex_is_mul_div (idex_q.is_mul_div),
    .amo_busy        (amo_busy),
    .amo_done        (amo_done),
    .md_done         (md_done),
    .idex_is_atomic  (idex_q.is_atomic),
    .stall_pc        (stall_pc),
    .stall_ifid      (stall_ifid),
    .bubble_idex     (bubble_idex),
    .idex_hold       (idex_hold)
  );

  // Only one unit can finish at a time, they share ID/EX
  assign ex_result_d = md_done ? md_result : amo_result;
  assign no_result   = !(md_done || amo_done);

  // EX result register, never held
  pipe_reg #(
    .payload_t (ex_result_t)
  ) result_reg_i (
    .clk    (clk),
    .reset  (reset),
    .hold   (1'b0),
    .bubble (no_result),
    .d      (ex_result_d),
    .q      (result_out)
  );

endmodule

// File: verification/tb_ex_stall_top.sv
// **************************************************
// Testbench for the execute-stage stall control
// Directed tests against a word memory model, with
// operands from a Galois LFSR
// **************************************************

`timescale 1ns/1ps

`include "core_defs.svh"

module tb_ex_stall_top;

  import rv_isa_pkg::*;
  import pipe_pkg::*;

  // Cycles any single wait may take
  localparam int TIMEOUT = 200;

  logic             clk = 1'b0;
  logic             reset;
  idex_t            id_instr;
  logic [`XLEN-1:0] mem_rdata = '0;
  logic             stall_pc;
  logic             stall_ifid;
  mem_req_t         mem_req;
  ex_result_t       result_out;

  // Word memory and the contents the tests expect in it
  logic [`XLEN-1:0] mem [0:63];
  logic [`XLEN-1:0] exp_mem [0:63];
  // Results seen on result_out, one entry per valid cycle
  ex_result_t       result_q[$];
  logic [31:0]      lfsr_state = 32'hb26a;
  int               checks = 0;
  int               errors = 0;

  ex_stall_top ex_stall_top_i (
    .clk        (clk),
    .reset      (reset),
    .id_instr   (id_instr),
    .mem_rdata  (mem_rdata),
    .stall_pc   (stall_pc),
    .stall_ifid (stall_ifid),
    .mem_req    (mem_req),
    .result_out (result_out)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // Strobes sampled mid-cycle
  // Read data and writes land just after the next rising edge
  always @(negedge clk) begin
    mem_req_t req;
    req = mem_req;
    @(posedge clk);
    #0.5;
    if (req.read) begin
      mem_rdata = mem[req.addr[7:2]];
    end
    if (req.write) begin
      mem[req.addr[7:2]] = req.wdata;
    end
  end

  // Sampled mid-cycle where result_out is stable
  always @(negedge clk) begin
    if (!reset && result_out.valid) begin
      result_q.push_back(result_out);
    end
  end

  // Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic next_rand_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h80200003;
    end
    return out;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_word(input int nbits);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < nbits; i++) begin
      v = {v[30:0], next_rand_bit()};
    end
    return v;
  endfunction

  // Reference arithmetic, unsigned, RISC-V divide-by-zero rule
  function automatic logic [`XLEN-1:0] md_expect(
    input md_op_e op,
    input logic [`XLEN-1:0] a,
    input logic [`XLEN-1:0] b
  );
    logic [2*`XLEN-1:0] prod;
    prod = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
    case (op)
      MD_MUL:   return prod[`XLEN-1:0];
      MD_MULHU: return prod[2*`XLEN-1:`XLEN];
      MD_DIVU:  return (b == '0) ? '1 : a / b;
      default:  return (b == '0) ? a : a % b;
    endcase
  endfunction

  function automatic logic [`XLEN-1:0] amo_expect(
    input amo_op_e op,
    input logic [`XLEN-1:0] old_val,
    input logic [`XLEN-1:0] src
  );
    case (op)
      AMO_ADD: return old_val + src;
      AMO_AND: return old_val & src;
      AMO_OR:  return old_val | src;
      AMO_XOR: return old_val ^ src;
      default: return src;
    endcase
  endfunction

  // Instruction bundles as ID would present them
  function automatic idex_t make_plain(input reg_addr_t rd, input reg_addr_t rs1,
                                       input reg_addr_t rs2, input logic load);
    idex_t t;
    t = '0;
    t.valid    = 1'b1;
    t.rd       = rd;
    t.rs1      = rs1;
    t.rs2      = rs2;
    t.mem_read = load;
    return t;
  endfunction

  function automatic idex_t make_md(input md_op_e op, input reg_addr_t rd,
                                    input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
    idex_t t;
    t = '0;
    t.valid      = 1'b1;
    t.rd         = rd;
    t.is_mul_div = 1'b1;
    t.md_op      = op;
    t.rs1_val    = a;
    t.rs2_val    = b;
    return t;
  endfunction

  function automatic idex_t make_amo(input amo_op_e op, input reg_addr_t rd,
                                     input logic [`XLEN-1:0] addr,
                                     input logic [`XLEN-1:0] src);
    idex_t t;
    t = '0;
    t.valid     = 1'b1;
    t.rd        = rd;
    t.is_atomic = 1'b1;
    t.amo_op    = op;
    t.rs1_val   = addr;
    t.rs2_val   = src;
    return t;
  endfunction

  task automatic abort_run(input string why);
    $display("Error: %s", why);
    $display("** FAIL **");
    $finish;
  endtask

  // Back to the drive point just after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #0.5;
  endtask

  // Present one instruction and hold it until ID/EX takes it
  task automatic issue_instr(input idex_t instr);
    int waited;
    waited = 0;
    id_instr = instr;
    @(negedge clk);
    while (stall_pc && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (stall_pc) begin
      abort_run("stall_pc never released, instruction in ID was not accepted");
    end else begin
      step_cycle();
      id_instr = '0;
    end
  endtask

  task automatic wait_result(output ex_result_t r);
    int waited;
    waited = 0;
    while (result_q.size() == 0 && waited < TIMEOUT) begin
      step_cycle();
      waited++;
    end
    if (result_q.size() == 0) begin
      abort_run("no valid result appeared on result_out");
    end else begin
      r = result_q.pop_front();
    end
  endtask

  task automatic check_result(input ex_result_t got, input ex_result_t want,
                              input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Fail at %0.1f ns: %s got valid=%b rd=%0d data=%h, expected valid=%b rd=%0d data=%h",
               $realtime, what, got.valid, got.rd, got.data, want.valid, want.rd, want.data);
    end
  endtask

  task automatic check_mem(input int idx, input logic [`XLEN-1:0] want, input string what);
    checks++;
    if (mem[idx] !== want) begin
      errors++;
      $display("Fail at %0.1f ns: %s memory word %0d is %h, expected %h",
               $realtime, what, idx, mem[idx], want);
    end
  endtask

  // Checked at the negative edge
  task automatic check_stall(input logic want, input string what);
    checks++;
    if (stall_pc !== want || stall_ifid !== want) begin
      errors++;
      $display("Fail at %0.1f ns: %s stall_pc=%b stall_ifid=%b, expected %b",
               $realtime, what, stall_pc, stall_ifid, want);
    end
  endtask

  // Nothing left running, no leftover result pulses
  task automatic expect_idle(input string what);
    repeat (3) step_cycle();
    @(negedge clk);
    check_stall(1'b0, what);
    step_cycle();
    if (result_q.size() != 0) begin
      errors++;
      $display("Unexpected extra result pulse on result_out after %s", what);
      result_q.delete();
    end
  endtask

  task automatic md_round(input md_op_e op, input logic [`XLEN-1:0] a,
                          input logic [`XLEN-1:0] b);
    ex_result_t got;
    ex_result_t want;
    reg_addr_t  rd;
    rd = reg_addr_t'(rand_word(`REG_ADDR_W));
    issue_instr(make_md(op, rd, a, b));
    wait_result(got);
    want.valid = 1'b1;
    want.rd    = rd;
    want.data  = md_expect(op, a, b);
    check_result(got, want, $sformatf("%s %h, %h", op.name(), a, b));
  endtask

  task automatic load_use_test();
    // Reader of x5 right behind a load to x5
    issue_instr(make_plain(5'd5, 5'd1, 5'd0, 1'b1));
    id_instr = make_plain(5'd6, 5'd5, 5'd2, 1'b0);
    @(negedge clk);
    check_stall(1'b1, "load-use on x5, first cycle");
    step_cycle();
    @(negedge clk);
    check_stall(1'b0, "load-use on x5, bubble in ID/EX");
    step_cycle();
    id_instr = '0;
    // x0 never creates a dependency
    issue_instr(make_plain(5'd0, 5'd1, 5'd0, 1'b1));
    id_instr = make_plain(5'd7, 5'd0, 5'd0, 1'b0);
    @(negedge clk);
    check_stall(1'b0, "load to x0 followed by reader of x0");
    step_cycle();
    id_instr = '0;
    expect_idle("load-use test");
  endtask

  task automatic multiply_test();
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    int               n;
    for (n = 0; n < 3; n++) begin
      a = rand_word(`XLEN);
      b = rand_word(`XLEN);
      md_round(MD_MUL, a, b);
      md_round(MD_MULHU, a, b);
    end
    // Largest operands fill all 64 product bits
    md_round(MD_MULHU, '1, '1);
    expect_idle("multiply test");
  endtask

  task automatic divide_test();
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    int               n;
    for (n = 0; n < 3; n++) begin
      a = rand_word(`XLEN);
      // Alternate wide and narrow divisors
      b = (n == 1) ? (rand_word(8) | 32'd1) : rand_word(`XLEN);
      md_round(MD_DIVU, a, b);
      md_round(MD_REMU, a, b);
    end
    a = rand_word(`XLEN);
    md_round(MD_DIVU, a, '0);
    md_round(MD_REMU, a, '0);
    expect_idle("divide test");
  endtask

  task automatic m_stall_test();
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    ex_result_t       got;
    ex_result_t       want;
    int               i;
    a = rand_word(`XLEN);
    b = rand_word(`XLEN);
    issue_instr(make_md(MD_MUL, 5'd9, a, b));
    // Next M op waits in ID for the whole multiply
    id_instr = make_md(MD_MULHU, 5'd10, a, b);
    for (i = 0; i < `DIV_STEPS; i++) begin
      @(negedge clk);
      check_stall(1'b1, "M instruction occupying EX");
      step_cycle();
    end
    @(negedge clk);
    check_stall(1'b0, "M unit done pulse");
    step_cycle();
    id_instr = '0;
    @(negedge clk);
    checks++;
    if (!result_out.valid) begin
      errors++;
      $display("Fail at %0.1f ns: result_out not valid right after the M stall released",
               $realtime);
    end
    step_cycle();
    wait_result(got);
    want.valid = 1'b1;
    want.rd    = 5'd9;
    want.data  = md_expect(MD_MUL, a, b);
    check_result(got, want, "MUL under stall");
    wait_result(got);
    want.rd   = 5'd10;
    want.data = md_expect(MD_MULHU, a, b);
    check_result(got, want, "MULHU accepted after stall");
    expect_idle("M stall test");
  endtask

  task automatic atomic_test();
    ex_result_t       got;
    ex_result_t       want;
    amo_op_e          op;
    logic [5:0]       idx;
    logic [`XLEN-1:0] src;
    logic [`XLEN-1:0] src2;
    logic [`XLEN-1:0] old_val;
    int               k;
    want.valid = 1'b1;
    for (k = 0; k < 5; k++) begin
      op      = amo_op_e'(k);
      idx     = 6'(rand_word(6));
      src     = rand_word(`XLEN);
      old_val = exp_mem[idx];
      exp_mem[idx] = amo_expect(op, old_val, src);
      issue_instr(make_amo(op, 5'(k + 11), {24'd0, idx, 2'b00}, src));
      wait_result(got);
      want.rd   = 5'(k + 11);
      want.data = old_val;
      check_result(got, want, op.name());
      check_mem(idx, exp_mem[idx], op.name());
    end
    // Two AMOs on one word, the second reads what the first wrote
    idx  = 6'(rand_word(6));
    src  = rand_word(`XLEN);
    src2 = rand_word(`XLEN);
    issue_instr(make_amo(AMO_ADD, 5'd20, {24'd0, idx, 2'b00}, src));
    issue_instr(make_amo(AMO_XOR, 5'd21, {24'd0, idx, 2'b00}, src2));
    wait_result(got);
    want.rd   = 5'd20;
    want.data = exp_mem[idx];
    check_result(got, want, "first of back-to-back AMOs");
    exp_mem[idx] = amo_expect(AMO_ADD, exp_mem[idx], src);
    wait_result(got);
    want.rd   = 5'd21;
    want.data = exp_mem[idx];
    check_result(got, want, "second of back-to-back AMOs");
    exp_mem[idx] = amo_expect(AMO_XOR, exp_mem[idx], src2);
    check_mem(idx, exp_mem[idx], "back-to-back AMOs");
    expect_idle("atomic test");
  endtask

  initial begin
    int i;
    reset    = 1'b1;
    id_instr = '0;
    // Fill pattern built from the full word index
    for (i = 0; i < 64; i++) begin
      mem[i]     = (32'(i) * 32'h9e3779b1) ^ 32'h0f1e2d3c;
      exp_mem[i] = mem[i];
    end
    repeat (10) @(posedge clk);
    #0.5;
    reset = 1'b0;
    step_cycle();
    load_use_test();
    multiply_test();
    divide_test();
    m_stall_test();
    atomic_test();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: ex_stall_top.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/hazard_detection_unit.sv
rtl/mul_div_unit.sv
rtl/atomic_unit.sv
rtl/pipe_reg.sv
rtl/ex_stall_top.sv
verification/tb_ex_stall_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute-stage stall control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_ex_stall_top \
  -f ex_stall_top.f \
  --Mdir obj_dir -o tb_ex_stall_top

./obj_dir/tb_ex_stall_top | tee sim.log

if grep -Fqx "** PASS **" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
